// File: rtl/tti_pkg.sv
/* I3C TTI shared types */

package tti_pkg;

    localparam int unsigned DescWidth  = 32;
    localparam int unsigned LevelWidth = 8;
    localparam int unsigned AddrWidth  = 8;

    localparam logic [AddrWidth-1:0] StatusAddr     = 8'h00;
    localparam logic [AddrWidth-1:0] ResetCtrlAddr  = 8'h04;
    localparam logic [AddrWidth-1:0] ThldCtrlAddr   = 8'h08;
    localparam logic [AddrWidth-1:0] RxDescPortAddr = 8'h0C;
    localparam logic [AddrWidth-1:0] TxDescPortAddr = 8'h10;

    // STATUS word, levels in the low bytes
    typedef struct packed {
        logic [DescWidth-2*LevelWidth-3:0] rsvd;
        logic                              tx_thld_hit;
        logic                              rx_thld_hit;
        logic [LevelWidth-1:0]             tx_level;
        logic [LevelWidth-1:0]             rx_level;
    } tti_status_t;

    typedef struct packed {
        logic [DescWidth-2*LevelWidth-1:0] rsvd;
        logic [LevelWidth-1:0]             tx_thld;
        logic [LevelWidth-1:0]             rx_thld;
    } tti_thld_ctrl_t;

    typedef struct packed {
        logic [DescWidth-3:0] rsvd;
        logic                 tx_rst;
        logic                 rx_rst;
    } tti_rst_ctrl_t;

    // Register block to bridge
    typedef struct packed {
        logic [LevelWidth-1:0] rx_thld;
        logic [LevelWidth-1:0] tx_thld;
        logic                  rx_thld_swmod;
        logic                  tx_thld_swmod;
        logic                  rx_rst;
        logic                  tx_rst;
        logic                  rx_port_req;
        logic                  tx_port_req;
        logic [DescWidth-1:0]  tx_port_wdata;
    } tti_hwif_out_t;

    // Bridge to register block
    typedef struct packed {
        logic                  rx_thld_we;
        logic [LevelWidth-1:0] rx_thld_next;
        logic                  tx_thld_we;
        logic [LevelWidth-1:0] tx_thld_next;
        logic                  rx_rst_we;
        logic                  tx_rst_we;
        logic                  rx_port_ack;
        logic                  rx_port_err;
        logic [DescWidth-1:0]  rx_port_rdata;
        logic                  tx_port_ack;
        logic                  tx_port_err;
        tti_status_t           status;
    } tti_hwif_in_t;

    typedef struct packed {
        logic                  push;
        logic [DescWidth-1:0]  push_data;
        logic                  pop;
        logic [LevelWidth-1:0] thld;
        logic                  flush;
    } tti_queue_ctl_t;

    typedef struct packed {
        logic                  full;
        logic                  empty;
        logic [DescWidth-1:0]  pop_data;
        logic [LevelWidth-1:0] level;
        logic                  thld_hit;
        logic [LevelWidth-1:0] thld_clamped;
        logic                  flush_done;
    } tti_queue_stat_t;

endpackage

// File: rtl/tti_csr.sv
/* TTI APB register block */

`timescale 1ns/1ps

module tti_csr (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [tti_pkg::AddrWidth-1:0]     paddr_i,
    input  logic [tti_pkg::DescWidth-1:0]     pwdata_i,
    output logic [tti_pkg::DescWidth-1:0]     prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,

    output tti_pkg::tti_hwif_out_t            hwif_o,
    input  tti_pkg::tti_hwif_in_t             hwif_i
);

    logic access;
    logic wr_en;
    logic rst_wr_sel;
    logic thld_wr_sel;
    logic rx_port_req;
    logic tx_port_req;

    logic                           rx_rst_q;
    logic                           tx_rst_q;
    logic [tti_pkg::LevelWidth-1:0] rx_thld_q;
    logic [tti_pkg::LevelWidth-1:0] tx_thld_q;

    tti_pkg::tti_rst_ctrl_t  rst_wr;
    tti_pkg::tti_rst_ctrl_t  rst_rd;
    tti_pkg::tti_thld_ctrl_t thld_wr;
    tti_pkg::tti_thld_ctrl_t thld_rd;

    // Access phase of an APB transfer
    assign access      = psel_i & penable_i;
    assign wr_en       = access & pwrite_i;
    assign rst_wr_sel  = wr_en && (paddr_i == tti_pkg::ResetCtrlAddr);
    assign thld_wr_sel = wr_en && (paddr_i == tti_pkg::ThldCtrlAddr);

    assign rst_wr  = pwdata_i;
    assign thld_wr = pwdata_i;

    // Hardware write-back wins over software
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_rst_q <= 1'b0;
            tx_rst_q <= 1'b0;
        end else begin
            if (hwif_i.rx_rst_we) begin
                rx_rst_q <= 1'b0;
            end else if (rst_wr_sel) begin
                rx_rst_q <= rst_wr.rx_rst;
            end
            if (hwif_i.tx_rst_we) begin
                tx_rst_q <= 1'b0;
            end else if (rst_wr_sel) begin
                tx_rst_q <= rst_wr.tx_rst;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_thld_q <= '0;
            tx_thld_q <= '0;
        end else begin
            if (hwif_i.rx_thld_we) begin
                rx_thld_q <= hwif_i.rx_thld_next;
            end else if (thld_wr_sel) begin
                rx_thld_q <= thld_wr.rx_thld;
            end
            if (hwif_i.tx_thld_we) begin
                tx_thld_q <= hwif_i.tx_thld_next;
            end else if (thld_wr_sel) begin
                tx_thld_q <= thld_wr.tx_thld;
            end
        end
    end

    always_comb begin
        rst_rd        = '0;
        rst_rd.rx_rst = rx_rst_q;
        rst_rd.tx_rst = tx_rst_q;

        thld_rd         = '0;
        thld_rd.rx_thld = rx_thld_q;
        thld_rd.tx_thld = tx_thld_q;
    end

    // Address decode and read mux
    always_comb begin
        prdata_o    = '0;
        pready_o    = access;
        pslverr_o   = 1'b0;
        rx_port_req = 1'b0;
        tx_port_req = 1'b0;
        if (access) begin
            case (paddr_i)
                tti_pkg::StatusAddr: begin
                    prdata_o = hwif_i.status;
                end
                tti_pkg::ResetCtrlAddr: begin
                    prdata_o = rst_rd;
                end
                tti_pkg::ThldCtrlAddr: begin
                    prdata_o = thld_rd;
                end
                tti_pkg::RxDescPortAddr: begin
                    // Read-only port
                    if (pwrite_i) begin
                        pslverr_o = 1'b1;
                    end else begin
                        rx_port_req = 1'b1;
                        pready_o    = hwif_i.rx_port_ack;
                        pslverr_o   = hwif_i.rx_port_err;
                        prdata_o    = hwif_i.rx_port_rdata;
                    end
                end
                tti_pkg::TxDescPortAddr: begin
                    // Write-only port
                    if (!pwrite_i) begin
                        pslverr_o = 1'b1;
                    end else begin
                        tx_port_req = 1'b1;
                        pready_o    = hwif_i.tx_port_ack;
                        pslverr_o   = hwif_i.tx_port_err;
                    end
                end
                default: begin
                    pslverr_o = 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        hwif_o.rx_thld       = rx_thld_q;
        hwif_o.tx_thld       = tx_thld_q;
        hwif_o.rx_thld_swmod = thld_wr_sel;
        hwif_o.tx_thld_swmod = thld_wr_sel;
        hwif_o.rx_rst        = rx_rst_q;
        hwif_o.tx_rst        = tx_rst_q;
        hwif_o.rx_port_req   = rx_port_req;
        hwif_o.tx_port_req   = tx_port_req;
        hwif_o.tx_port_wdata = pwdata_i;
    end

endmodule

// File: rtl/tti_desc_queue.sv
/* TTI descriptor queue */

`timescale 1ns/1ps

module tti_desc_queue #(
    parameter int unsigned Depth = 8,
    parameter bit          IsTx  = 1'b0
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    input  tti_pkg::tti_queue_ctl_t        ctl_i,
    output tti_pkg::tti_queue_stat_t       stat_o,

    input  logic                           in_valid_i,
    input  logic [tti_pkg::DescWidth-1:0]  in_data_i,
    output logic                           in_ready_o,

    output logic                           out_valid_o,
    output logic [tti_pkg::DescWidth-1:0]  out_data_o,
    input  logic                           out_ready_i
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
    localparam logic [tti_pkg::LevelWidth-1:0] DepthLevel = tti_pkg::LevelWidth'(Depth);

    logic [tti_pkg::DescWidth-1:0]  mem_q [Depth];
    logic [PtrWidth-1:0]            wr_ptr_q;
    logic [PtrWidth-1:0]            rd_ptr_q;
    logic [tti_pkg::LevelWidth-1:0] level_q;
    logic [tti_pkg::LevelWidth-1:0] level_d;
    logic [tti_pkg::LevelWidth-1:0] thld_clamped_q;
    logic [tti_pkg::LevelWidth-1:0] thld_clamped_d;
    logic                           thld_hit_q;
    logic                           thld_hit_d;

    logic                           full;
    logic                           empty;
    logic                           push_ok;
    logic                           pop_ok;
    logic [tti_pkg::DescWidth-1:0]  push_data;

    assign full  = (level_q == DepthLevel);
    assign empty = (level_q == '0);

    assign in_ready_o  = ~full;
    assign out_valid_o = ~empty;
    assign out_data_o  = mem_q[rd_ptr_q];

    // Register port or engine handshake, one of them per instance
    assign push_ok   = (ctl_i.push | (in_valid_i & in_ready_o)) & ~full & ~ctl_i.flush;
    assign pop_ok    = (ctl_i.pop | (out_valid_o & out_ready_i)) & ~empty & ~ctl_i.flush;
    assign push_data = ctl_i.push ? ctl_i.push_data : in_data_i;

    always_comb begin
        level_d = level_q;
        if (ctl_i.flush) begin
            level_d = '0;
        end else if (push_ok && !pop_ok) begin
            level_d = level_q + 1'b1;
        end else if (!push_ok && pop_ok) begin
            level_d = level_q - 1'b1;
        end
    end

    assign thld_clamped_d = (ctl_i.thld > DepthLevel) ? DepthLevel : ctl_i.thld;

    // Zero threshold disables the flag
    // RX flags a filling queue, TX a draining one
    assign thld_hit_d = (thld_clamped_d != '0) &&
                        (IsTx ? (level_d <= thld_clamped_d) : (level_d >= thld_clamped_d));

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            level_q        <= '0;
            thld_clamped_q <= '0;
            thld_hit_q     <= 1'b0;
        end else begin
            if (ctl_i.flush) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else begin
                if (push_ok) begin
                    wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop_ok) begin
                    rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
                end
            end
            level_q        <= level_d;
            thld_clamped_q <= thld_clamped_d;
            thld_hit_q     <= thld_hit_d;
        end
    end

    always_comb begin
        stat_o.full         = full;
        stat_o.empty        = empty;
        stat_o.pop_data     = mem_q[rd_ptr_q];
        stat_o.level        = level_q;
        stat_o.thld_hit     = thld_hit_q;
        stat_o.thld_clamped = thld_clamped_q;
        stat_o.flush_done   = ctl_i.flush;
    end

endmodule

// File: rtl/tti.sv
/* TTI register to queue bridge */

`timescale 1ns/1ps

module tti (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  tti_pkg::tti_hwif_out_t    hwif_i,
    output tti_pkg::tti_hwif_in_t     hwif_o,

    output tti_pkg::tti_queue_ctl_t   rx_ctl_o,
    output tti_pkg::tti_queue_ctl_t   tx_ctl_o,
    input  tti_pkg::tti_queue_stat_t  rx_stat_i,
    input  tti_pkg::tti_queue_stat_t  tx_stat_i,

    output logic                      irq_o
);

    logic rx_swmod_q;
    logic tx_swmod_q;
    logic rx_thld_we_q;
    logic tx_thld_we_q;
    logic irq_q;

    logic rx_pop;
    logic tx_push;

    // Two-stage delay so the queue has clamped the new threshold
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_swmod_q   <= 1'b0;
            tx_swmod_q   <= 1'b0;
            rx_thld_we_q <= 1'b0;
            tx_thld_we_q <= 1'b0;
        end else begin
            rx_swmod_q   <= hwif_i.rx_thld_swmod;
            tx_swmod_q   <= hwif_i.tx_thld_swmod;
            rx_thld_we_q <= rx_swmod_q;
            tx_thld_we_q <= tx_swmod_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= rx_stat_i.thld_hit | tx_stat_i.thld_hit;
        end
    end

    assign irq_o = irq_q;

    // Port accesses succeed only when the queue can take them
    assign rx_pop  = hwif_i.rx_port_req & ~rx_stat_i.empty;
    assign tx_push = hwif_i.tx_port_req & ~tx_stat_i.full;

    always_comb begin
        rx_ctl_o.push      = 1'b0;
        rx_ctl_o.push_data = '0;
        rx_ctl_o.pop       = rx_pop;
        rx_ctl_o.thld      = hwif_i.rx_thld;
        rx_ctl_o.flush     = hwif_i.rx_rst;

        tx_ctl_o.push      = tx_push;
        tx_ctl_o.push_data = hwif_i.tx_port_wdata;
        tx_ctl_o.pop       = 1'b0;
        tx_ctl_o.thld      = hwif_i.tx_thld;
        tx_ctl_o.flush     = hwif_i.tx_rst;
    end

    always_comb begin
        hwif_o.rx_thld_we   = rx_thld_we_q;
        hwif_o.rx_thld_next = rx_stat_i.thld_clamped;
        hwif_o.tx_thld_we   = tx_thld_we_q;
        hwif_o.tx_thld_next = tx_stat_i.thld_clamped;

        // Reset bits self-clear once the flush is taken
        hwif_o.rx_rst_we = rx_stat_i.flush_done;
        hwif_o.tx_rst_we = tx_stat_i.flush_done;

        hwif_o.rx_port_ack   = hwif_i.rx_port_req;
        hwif_o.rx_port_err   = hwif_i.rx_port_req & rx_stat_i.empty;
        hwif_o.rx_port_rdata = rx_pop ? rx_stat_i.pop_data : '0;
        hwif_o.tx_port_ack   = hwif_i.tx_port_req;
        hwif_o.tx_port_err   = hwif_i.tx_port_req & tx_stat_i.full;

        hwif_o.status             = '0;
        hwif_o.status.rx_level    = rx_stat_i.level;
        hwif_o.status.tx_level    = tx_stat_i.level;
        hwif_o.status.rx_thld_hit = rx_stat_i.thld_hit;
        hwif_o.status.tx_thld_hit = tx_stat_i.thld_hit;
    end

endmodule

// File: rtl/i3c_tti_top.sv
/* I3C TTI top level */

`timescale 1ns/1ps

module i3c_tti_top #(
    parameter int unsigned RxDepth = 8,
    parameter int unsigned TxDepth = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [tti_pkg::AddrWidth-1:0]  paddr_i,
    input  logic [tti_pkg::DescWidth-1:0]  pwdata_i,
    output logic [tti_pkg::DescWidth-1:0]  prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,

    input  logic                           rx_desc_valid_i,
    input  logic [tti_pkg::DescWidth-1:0]  rx_desc_i,
    output logic                           rx_desc_ready_o,

    output logic                           tx_desc_valid_o,
    output logic [tti_pkg::DescWidth-1:0]  tx_desc_o,
    input  logic                           tx_desc_ready_i,

    output logic                           irq_o
);

    tti_pkg::tti_hwif_out_t   hwif_out;
    tti_pkg::tti_hwif_in_t    hwif_in;
    tti_pkg::tti_queue_ctl_t  rx_ctl;
    tti_pkg::tti_queue_ctl_t  tx_ctl;
    tti_pkg::tti_queue_stat_t rx_stat;
    tti_pkg::tti_queue_stat_t tx_stat;

    tti_csr u_csr (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .hwif_o    (hwif_out),
        .hwif_i    (hwif_in)
    );

    tti u_tti (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .hwif_i    (hwif_out),
        .hwif_o    (hwif_in),
        .rx_ctl_o  (rx_ctl),
        .tx_ctl_o  (tx_ctl),
        .rx_stat_i (rx_stat),
        .tx_stat_i (tx_stat),
        .irq_o     (irq_o)
    );

    // Engine fills RX, software drains it
    tti_desc_queue #(
        .Depth (RxDepth),
        .IsTx  (1'b0)
    ) u_rx_queue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctl_i       (rx_ctl),
        .stat_o      (rx_stat),
        .in_valid_i  (rx_desc_valid_i),
        .in_data_i   (rx_desc_i),
        .in_ready_o  (rx_desc_ready_o),
        .out_valid_o (),
        .out_data_o  (),
        .out_ready_i (1'b0)
    );

    // Software fills TX, engine drains it
    tti_desc_queue #(
        .Depth (TxDepth),
        .IsTx  (1'b1)
    ) u_tx_queue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctl_i       (tx_ctl),
        .stat_o      (tx_stat),
        .in_valid_i  (1'b0),
        .in_data_i   ('0),
        .in_ready_o  (),
        .out_valid_o (tx_desc_valid_o),
        .out_data_o  (tx_desc_o),
        .out_ready_i (tx_desc_ready_i)
    );

endmodule

// File: sim/tb_i3c_tti.sv
/* I3C TTI testbench */

`timescale 1ns/1ps

module tb_i3c_tti;

    localparam int unsigned RxDepth = 8;
    localparam int unsigned TxDepth = 8;

    localparam logic [3:0] OpWrite   = 4'd0;
    localparam logic [3:0] OpRead    = 4'd1;
    localparam logic [3:0] OpIdle    = 4'd2;
    localparam logic [3:0] OpRxPush  = 4'd3;
    localparam logic [3:0] OpRxPop   = 4'd4;
    localparam logic [3:0] OpTxPush  = 4'd5;
    localparam logic [3:0] OpTxDrain = 4'd6;
    localparam logic [3:0] OpIrq     = 4'd7;
    localparam logic [3:0] OpRxReady = 4'd8;

    // One table row, counts for queue steps go in data
    typedef struct packed {
        logic [3:0]                    op;
        logic [tti_pkg::AddrWidth-1:0] addr;
        logic [tti_pkg::DescWidth-1:0] data;
        logic [tti_pkg::DescWidth-1:0] exp_rdata;
        logic                          exp_err;
    } step_t;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          psel_i;
    logic                          penable_i;
    logic                          pwrite_i;
    logic [tti_pkg::AddrWidth-1:0] paddr_i;
    logic [tti_pkg::DescWidth-1:0] pwdata_i;
    logic [tti_pkg::DescWidth-1:0] prdata_o;
    logic                          pready_o;
    logic                          pslverr_o;
    logic                          rx_desc_valid_i;
    logic [tti_pkg::DescWidth-1:0] rx_desc_i;
    logic                          rx_desc_ready_o;
    logic                          tx_desc_valid_o;
    logic [tti_pkg::DescWidth-1:0] tx_desc_o;
    logic                          tx_desc_ready_i;
    logic                          irq_o;

    step_t                         steps[$];
    string                         step_names[$];
    logic [tti_pkg::DescWidth-1:0] rx_sb[$];
    logic [tti_pkg::DescWidth-1:0] tx_sb[$];
    int                            cycle_count = 0;
    int                            timeout_limit = 1000;

    i3c_tti_top #(
        .RxDepth (RxDepth),
        .TxDepth (TxDepth)
    ) u_dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .rx_desc_valid_i (rx_desc_valid_i),
        .rx_desc_i       (rx_desc_i),
        .rx_desc_ready_o (rx_desc_ready_o),
        .tx_desc_valid_o (tx_desc_valid_o),
        .tx_desc_o       (tx_desc_o),
        .tx_desc_ready_i (tx_desc_ready_i),
        .irq_o           (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_step(input string name, input logic [3:0] op,
                            input logic [tti_pkg::AddrWidth-1:0] addr,
                            input logic [31:0] data, input logic [31:0] exp_rdata,
                            input logic exp_err);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.data      = data;
        s.exp_rdata = exp_rdata;
        s.exp_err   = exp_err;
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic apb_xfer(input logic write, input logic [tti_pkg::AddrWidth-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        // No ready outside the access phase
        @(negedge clk_i);
        check_value("apb setup ready", 32'h0, 32'(pready_o));
        @(posedge clk_i);
        #1;
        penable_i = 1'b1;
        @(negedge clk_i);
        while (!pready_o) begin
            @(negedge clk_i);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic push_rx(input int count);
        logic [31:0] desc;
        for (int i = 0; i < count; i++) begin
            desc            = $urandom;
            rx_desc_valid_i = 1'b1;
            rx_desc_i       = desc;
            @(negedge clk_i);
            while (!rx_desc_ready_o) begin
                @(negedge clk_i);
            end
            @(posedge clk_i);
            #1;
            rx_sb.push_back(desc);
        end
        rx_desc_valid_i = 1'b0;
    endtask

    // Engine side takes words with a random ready
    task automatic drain_tx(input string name, input int count);
        int taken;
        taken = 0;
        while (taken < count) begin
            tx_desc_ready_i = 1'($urandom % 2);
            @(negedge clk_i);
            if (tx_desc_valid_o && tx_desc_ready_i) begin
                check_value(name, tx_sb.pop_front(), tx_desc_o);
                taken++;
            end
            @(posedge clk_i);
            #1;
        end
        tx_desc_ready_i = 1'b0;
        check_value({name, " valid"}, 32'(tx_sb.size() != 0), 32'(tx_desc_valid_o));
    endtask

    task automatic run_step(input int idx);
        step_t       s;
        string       name;
        logic [31:0] rdata;
        logic [31:0] desc;
        logic        err;
        s    = steps[idx];
        name = step_names[idx];
        case (s.op)
            OpWrite: begin
                apb_xfer(1'b1, s.addr, s.data, rdata, err);
                check_value(name, 32'(s.exp_err), 32'(err));
                // A flush empties the matching queue
                if (s.addr == tti_pkg::ResetCtrlAddr && !s.exp_err) begin
                    if (s.data[0]) rx_sb.delete();
                    if (s.data[1]) tx_sb.delete();
                end
            end
            OpRead: begin
                apb_xfer(1'b0, s.addr, 32'h0, rdata, err);
                check_value(name, s.exp_rdata, rdata);
                check_value({name, " err"}, 32'(s.exp_err), 32'(err));
            end
            OpIdle: begin
                repeat (s.data) @(posedge clk_i);
                #1;
            end
            OpRxPush: push_rx(int'(s.data));
            OpRxPop: begin
                for (int i = 0; i < int'(s.data); i++) begin
                    apb_xfer(1'b0, tti_pkg::RxDescPortAddr, 32'h0, rdata, err);
                    check_value(name, rx_sb.pop_front(), rdata);
                    check_value({name, " err"}, 32'h0, 32'(err));
                end
            end
            OpTxPush: begin
                for (int i = 0; i < int'(s.data); i++) begin
                    desc = $urandom;
                    apb_xfer(1'b1, tti_pkg::TxDescPortAddr, desc, rdata, err);
                    check_value(name, 32'h0, 32'(err));
                    tx_sb.push_back(desc);
                end
            end
            OpTxDrain: drain_tx(name, int'(s.data));
            OpIrq:     check_value(name, s.data, 32'(irq_o));
            OpRxReady: check_value(name, s.data, 32'(rx_desc_ready_o));
            default: begin
                $display("Table row %0d holds an unknown operation", idx);
                $display("TESTBENCH FAILED");
                $fatal(1, "bad table row");
            end
        endcase
    endtask

    task automatic build_table();
        add_step("reset status", OpRead, tti_pkg::StatusAddr, 32'h0, 32'h0, 1'b0);
        add_step("reset rst ctrl", OpRead, tti_pkg::ResetCtrlAddr, 32'h0, 32'h0, 1'b0);
        add_step("reset thld ctrl", OpRead, tti_pkg::ThldCtrlAddr, 32'h0, 32'h0, 1'b0);
        add_step("reset irq", OpIrq, 8'h00, 32'd0, 32'h0, 1'b0);
        add_step("reset rx ready", OpRxReady, 8'h00, 32'd1, 32'h0, 1'b0);
        // RX 3, TX 20 clamps to the depth of 8
        add_step("thld write", OpWrite, tti_pkg::ThldCtrlAddr, 32'h0000_1403, 32'h0, 1'b0);
        add_step("thld settle", OpIdle, 8'h00, 32'd3, 32'h0, 1'b0);
        add_step("thld clamp", OpRead, tti_pkg::ThldCtrlAddr, 32'h0, 32'h0000_0803, 1'b0);
        add_step("rx push", OpRxPush, 8'h00, 32'd5, 32'h0, 1'b0);
        add_step("rx level", OpRead, tti_pkg::StatusAddr, 32'h0, 32'h0003_0005, 1'b0);
        add_step("rx irq", OpIrq, 8'h00, 32'd1, 32'h0, 1'b0);
        add_step("rx pop order", OpRxPop, 8'h00, 32'd5, 32'h0, 1'b0);
        add_step("rx pop empty", OpRead, tti_pkg::RxDescPortAddr, 32'h0, 32'h0, 1'b1);
        add_step("tx push", OpTxPush, 8'h00, 32'd8, 32'h0, 1'b0);
        add_step("tx push full", OpWrite, tti_pkg::TxDescPortAddr, 32'hdead_beef, 32'h0, 1'b1);
        add_step("tx level", OpRead, tti_pkg::StatusAddr, 32'h0, 32'h0002_0800, 1'b0);
        add_step("tx drain order", OpTxDrain, 8'h00, 32'd8, 32'h0, 1'b0);
        add_step("flush rx fill", OpRxPush, 8'h00, 32'd4, 32'h0, 1'b0);
        add_step("flush tx fill", OpTxPush, 8'h00, 32'd2, 32'h0, 1'b0);
        add_step("flush pre status", OpRead, tti_pkg::StatusAddr, 32'h0, 32'h0003_0204, 1'b0);
        add_step("flush write", OpWrite, tti_pkg::ResetCtrlAddr, 32'h1, 32'h0, 1'b0);
        add_step("flush wait", OpIdle, 8'h00, 32'd1, 32'h0, 1'b0);
        add_step("flush rst clear", OpRead, tti_pkg::ResetCtrlAddr, 32'h0, 32'h0, 1'b0);
        add_step("flush rx level", OpRead, tti_pkg::StatusAddr, 32'h0, 32'h0002_0200, 1'b0);
        add_step("flush tx kept", OpTxDrain, 8'h00, 32'd2, 32'h0, 1'b0);
        add_step("flush rx ready", OpRxReady, 8'h00, 32'd1, 32'h0, 1'b0);
        // TX threshold 0 leaves only the RX flag on the interrupt
        add_step("irq thld write", OpWrite, tti_pkg::ThldCtrlAddr, 32'h0000_0003, 32'h0, 1'b0);
        add_step("irq thld settle", OpIdle, 8'h00, 32'd3, 32'h0, 1'b0);
        add_step("irq low", OpIrq, 8'h00, 32'd0, 32'h0, 1'b0);
        add_step("irq rx fill", OpRxPush, 8'h00, 32'd3, 32'h0, 1'b0);
        add_step("irq rx settle", OpIdle, 8'h00, 32'd1, 32'h0, 1'b0);
        add_step("irq rx hit", OpIrq, 8'h00, 32'd1, 32'h0, 1'b0);
        add_step("unmapped read", OpRead, 8'h20, 32'h0, 32'h0, 1'b1);
        add_step("unmapped write", OpWrite, 8'h14, 32'h1234_5678, 32'h0, 1'b1);
    endtask

    initial begin
        void'($urandom(95));
        rst_ni          = 1'b0;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        rx_desc_valid_i = 1'b0;
        rx_desc_i       = '0;
        tx_desc_ready_i = 1'b0;

        build_table();
        timeout_limit = 20 * steps.size() + 200;

        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            run_step(i);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: src.f
rtl/tti_pkg.sv
rtl/tti_csr.sv
rtl/tti_desc_queue.sv
rtl/tti.sv
rtl/i3c_tti_top.sv
sim/tb_i3c_tti.sv

// File: Makefile
# Verilator build for the I3C TTI testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_tti
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
